// File: source/fcvt_pkg.sv
//--------------------------------------------------------------------------
// Conversion unit shared types, op and rounding codes, and round decision
//--------------------------------------------------------------------------
`default_nettype none

package fcvt_pkg;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------
  // Integer operand or result
  typedef logic [31:0] word_t;
  // Single-precision bit pattern
  typedef logic [31:0] fp32_t;
  // Bit 1 is int to float, bit 0 is unsigned
  typedef logic [1:0]  fcvt_op_t;
  // IEEE rounding mode as carried by the frm field
  typedef logic [2:0]  rm_t;

  // Operation codes
  localparam fcvt_op_t OP_W_S  = 2'b00;
  localparam fcvt_op_t OP_WU_S = 2'b01;
  localparam fcvt_op_t OP_S_W  = 2'b10;
  localparam fcvt_op_t OP_S_WU = 2'b11;

  // Rounding modes, 101 to 111 fall back to truncation
  localparam rm_t RM_RNE = 3'b000;
  localparam rm_t RM_RTZ = 3'b001;
  localparam rm_t RM_RDN = 3'b010;
  localparam rm_t RM_RUP = 3'b011;
  localparam rm_t RM_RMM = 3'b100;

  // Single-precision format
  localparam int FP_BIAS    = 127;
  localparam int FP_EXP_MAX = 255;

  // --------------------------------------------------------------------------
  // Round decision
  // --------------------------------------------------------------------------
  // Returns one when the kept magnitude must step up by one unit
  function automatic logic round_increment(input rm_t  rm,
                                           input logic sign,
                                           input logic lsb,
                                           input logic guard,
                                           input logic sticky);
    logic inc;
    case (rm)
      // Ties go to the even neighbour
      RM_RNE:  inc = guard & (sticky | lsb);
      RM_RTZ:  inc = 1'b0;
      // Toward minus infinity grows negative magnitudes only
      RM_RDN:  inc = sign & (guard | sticky);
      // Toward plus infinity grows positive magnitudes only
      RM_RUP:  inc = ~sign & (guard | sticky);
      // Ties away from zero
      RM_RMM:  inc = guard;
      default: inc = 1'b0;
    endcase
    return inc;
  endfunction

endpackage

`default_nettype wire

// File: source/fcvt_ctrl.sv
//--------------------------------------------------------------------------
// Conversion sequencer: start/busy/done handshake, operand capture,
// stage enables and output registers
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fcvt_ctrl import fcvt_pkg::*; (
  input  wire       clk,
  input  wire       reset_n,
  input  wire       start,
  input  fcvt_op_t  op,
  input  rm_t       rm,
  input  word_t     int_operand,
  input  fp32_t     fp_operand,
  input  fp32_t     i2f_result,
  input  wire       i2f_nx,
  input  word_t     f2i_result,
  input  wire       f2i_nv,
  input  wire       f2i_nx,
  output logic      busy,
  output logic      done,
  output logic      stage1_en,
  output logic      stage2_en,
  output logic      op_unsigned,
  output rm_t       rm_q,
  output word_t     int_q,
  output fp32_t     fp_q,
  output word_t     int_result,
  output fp32_t     fp_result,
  output logic      flag_nv,
  output logic      flag_nx
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_NORMALIZE,
    ST_ROUND,
    ST_DONE
  } state_t;

  state_t   state;
  fcvt_op_t op_q;
  logic     accept;

  // Start only counts while idle, nothing is queued
  assign accept = start & (state == ST_IDLE);

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:      state <= accept ? ST_NORMALIZE : ST_IDLE;
        ST_NORMALIZE: state <= ST_ROUND;
        ST_ROUND:     state <= ST_DONE;
        default:      state <= ST_IDLE;
      endcase
    end
  end

  assign busy      = (state != ST_IDLE);
  // Stage 1 of each datapath, then stage 2 one cycle later
  assign stage1_en = (state == ST_NORMALIZE);
  assign stage2_en = (state == ST_ROUND);

  // Operand capture on acceptance, caller is free afterwards
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q  <= op;
      rm_q  <= rm;
      int_q <= int_operand;
      fp_q  <= fp_operand;
    end
  end

  assign op_unsigned = op_q[0];

  // --------------------------------------------------------------------------
  // Result select and output registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      done       <= 1'b0;
      int_result <= '0;
      fp_result  <= '0;
      flag_nv    <= 1'b0;
      flag_nx    <= 1'b0;
    end else begin
      // One-cycle pulse as the DONE state is left
      done <= (state == ST_DONE);
      if (state == ST_DONE) begin
        unique case (op_q)
          OP_W_S, OP_WU_S: begin
            int_result <= f2i_result;
            fp_result  <= '0;
            flag_nv    <= f2i_nv;
            flag_nx    <= f2i_nx;
          end
          OP_S_W, OP_S_WU: begin
            int_result <= '0;
            fp_result  <= i2f_result;
            // Every integer is representable, never invalid
            flag_nv    <= 1'b0;
            flag_nx    <= i2f_nx;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: source/fcvt_int_to_fp.sv
//--------------------------------------------------------------------------
// Integer to single conversion, normalize stage then round stage
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fcvt_int_to_fp import fcvt_pkg::*; (
  input  wire   clk,
  input  wire   reset_n,
  input  wire   stage1_en,
  input  wire   stage2_en,
  input  wire   op_unsigned,
  input  rm_t   rm_q,
  input  word_t int_q,
  output fp32_t i2f_result,
  output logic  i2f_nx
);

  logic        neg;
  word_t       mag;
  logic [4:0]  lzc;
  word_t       norm;

  // Stage 1 registers
  logic        s1_zero;
  logic        s1_sign;
  logic [7:0]  s1_exp;
  logic [22:0] s1_man;
  logic        s1_guard;
  logic        s1_sticky;

  logic        inc;
  logic [23:0] man_sum;

  // --------------------------------------------------------------------------
  // Stage 1: sign, magnitude, leading zero count, normalize
  // --------------------------------------------------------------------------
  always_comb begin
    // Unsigned operands are never negative
    neg = ~op_unsigned & int_q[31];
    mag = neg ? (~int_q + 32'd1) : int_q;
    // Highest set bit wins
    lzc = 5'd0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) begin
        lzc = 5'(31 - i);
      end
    end
    // Leading one lands in bit 31 and is hidden
    norm = mag << lzc;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      s1_zero   <= 1'b0;
      s1_sign   <= 1'b0;
      s1_exp    <= '0;
      s1_man    <= '0;
      s1_guard  <= 1'b0;
      s1_sticky <= 1'b0;
    end else if (stage1_en) begin
      s1_zero   <= (mag == '0);
      s1_sign   <= neg;
      s1_exp    <= 8'(FP_BIAS + 31) - {3'b000, lzc};
      s1_man    <= norm[30:8];
      s1_guard  <= norm[7];
      s1_sticky <= |norm[6:0];
    end
  end

  // --------------------------------------------------------------------------
  // Stage 2: round, carry into exponent
  // --------------------------------------------------------------------------
  assign inc     = round_increment(rm_q, s1_sign, s1_man[0], s1_guard, s1_sticky);
  // All-ones mantissa plus one wraps to zero and carries out
  assign man_sum = {1'b0, s1_man} + {23'd0, inc};

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      i2f_result <= '0;
      i2f_nx     <= 1'b0;
    end else if (stage2_en) begin
      if (s1_zero) begin
        // Plus zero, exact
        i2f_result <= '0;
        i2f_nx     <= 1'b0;
      end else begin
        // Exponent tops out at 159, no overflow possible
        i2f_result <= {s1_sign, s1_exp + {7'd0, man_sum[23]}, man_sum[22:0]};
        i2f_nx     <= s1_guard | s1_sticky;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/fcvt_fp_to_int.sv
//--------------------------------------------------------------------------
// Single to integer conversion, classify and align stage then round and
// saturate stage
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fcvt_fp_to_int import fcvt_pkg::*; (
  input  wire   clk,
  input  wire   reset_n,
  input  wire   stage1_en,
  input  wire   stage2_en,
  input  wire   op_unsigned,
  input  rm_t   rm_q,
  input  fp32_t fp_q,
  output word_t f2i_result,
  output logic  f2i_nv,
  output logic  f2i_nx
);

  logic              exp_all_ones;
  logic [7:0]        exp_eff;
  logic [23:0]       mant;
  logic signed [9:0] unb_exp;
  logic [5:0]        shamt;
  logic [57:0]       aligned;

  // Stage 1 registers
  logic        s1_sign;
  logic        s1_nan;
  logic        s1_inf;
  logic        s1_big;
  logic [32:0] s1_int;
  logic        s1_guard;
  logic        s1_sticky;

  logic        inc;
  logic [32:0] mag;
  logic        ovf;
  word_t       sat_pos;
  word_t       sat_neg;
  word_t       res_d;
  logic        nv_d;
  logic        nx_d;

  // --------------------------------------------------------------------------
  // Stage 1: classify, right-align against the unbiased exponent
  // --------------------------------------------------------------------------
  assign exp_all_ones = (fp_q[30:23] == 8'(FP_EXP_MAX));
  // Subnormals use exponent 1 without the hidden bit; zero drops out as 0
  assign exp_eff = (fp_q[30:23] == 8'd0) ? 8'd1 : fp_q[30:23];
  assign mant    = {fp_q[30:23] != 8'd0, fp_q[22:0]};
  assign unb_exp = $signed({2'b00, exp_eff}) - $signed(10'(FP_BIAS));

  always_comb begin
    // Tiny values clamp so the mantissa only feeds sticky
    if (unb_exp < -10'sd2) begin
      shamt = 6'd33;
    end else if (unb_exp > 10'sd31) begin
      shamt = 6'd0;
    end else begin
      shamt = 6'(10'sd31 - unb_exp);
    end
    // Units bit sits at index 25, guard at 24
    aligned = {1'b0, mant, 33'd0} >> shamt;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      s1_sign   <= 1'b0;
      s1_nan    <= 1'b0;
      s1_inf    <= 1'b0;
      s1_big    <= 1'b0;
      s1_int    <= '0;
      s1_guard  <= 1'b0;
      s1_sticky <= 1'b0;
    end else if (stage1_en) begin
      s1_sign   <= fp_q[31];
      s1_nan    <= exp_all_ones & (fp_q[22:0] != '0);
      s1_inf    <= exp_all_ones & (fp_q[22:0] == '0);
      s1_big    <= (unb_exp > 10'sd31);
      s1_int    <= aligned[57:25];
      s1_guard  <= aligned[24];
      s1_sticky <= |aligned[23:0];
    end
  end

  // --------------------------------------------------------------------------
  // Stage 2: round, sign, saturate
  // --------------------------------------------------------------------------
  // Magnitude below 2^32, so the 33-bit sum cannot wrap
  assign inc = round_increment(rm_q, s1_sign, s1_int[0], s1_guard, s1_sticky);
  assign mag = s1_int + {32'd0, inc};

  assign sat_pos = op_unsigned ? 32'hffff_ffff : 32'h7fff_ffff;
  assign sat_neg = op_unsigned ? 32'h0000_0000 : 32'h8000_0000;

  always_comb begin
    // Range check on the rounded magnitude
    if (op_unsigned) begin
      ovf = s1_sign ? (mag != '0) : mag[32];
    end else begin
      ovf = s1_sign ? (mag > 33'h0_8000_0000) : (mag > 33'h0_7fff_ffff);
    end
    nv_d = 1'b1;
    nx_d = 1'b0;
    if (s1_nan) begin
      res_d = sat_pos;
    end else if (s1_inf || s1_big || ovf) begin
      res_d = s1_sign ? sat_neg : sat_pos;
    end else begin
      // Unsigned negative that rounds to zero lands here as exact 0
      res_d = s1_sign ? (~mag[31:0] + 32'd1) : mag[31:0];
      nv_d  = 1'b0;
      nx_d  = s1_guard | s1_sticky;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      f2i_result <= '0;
      f2i_nv     <= 1'b0;
      f2i_nx     <= 1'b0;
    end else if (stage2_en) begin
      f2i_result <= res_d;
      f2i_nv     <= nv_d;
      f2i_nx     <= nx_d;
    end
  end

endmodule

`default_nettype wire

// File: source/fcvt_unit.sv
//--------------------------------------------------------------------------
// RISC-V single-precision conversion unit top level
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fcvt_unit import fcvt_pkg::*; (
  input  wire      clk,
  input  wire      reset_n,
  input  wire      start,
  input  fcvt_op_t op,
  input  rm_t      rm,
  input  word_t    int_operand,
  input  fp32_t    fp_operand,
  output logic     busy,
  output logic     done,
  output word_t    int_result,
  output fp32_t    fp_result,
  output logic     flag_nv,
  output logic     flag_nx
);

  // Sequencer to datapaths
  logic  stage1_en;
  logic  stage2_en;
  logic  op_unsigned;
  rm_t   rm_q;
  word_t int_q;
  fp32_t fp_q;

  // Datapaths back to the sequencer
  fp32_t i2f_result;
  logic  i2f_nx;
  word_t f2i_result;
  logic  f2i_nv;
  logic  f2i_nx;

  fcvt_ctrl ctrl_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       (start),
    .op          (op),
    .rm          (rm),
    .int_operand (int_operand),
    .fp_operand  (fp_operand),
    .i2f_result  (i2f_result),
    .i2f_nx      (i2f_nx),
    .f2i_result  (f2i_result),
    .f2i_nv      (f2i_nv),
    .f2i_nx      (f2i_nx),
    .busy        (busy),
    .done        (done),
    .stage1_en   (stage1_en),
    .stage2_en   (stage2_en),
    .op_unsigned (op_unsigned),
    .rm_q        (rm_q),
    .int_q       (int_q),
    .fp_q        (fp_q),
    .int_result  (int_result),
    .fp_result   (fp_result),
    .flag_nv     (flag_nv),
    .flag_nx     (flag_nx)
  );

  // Both datapaths step together, the sequencer picks one by op
  fcvt_int_to_fp i2f_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .stage1_en   (stage1_en),
    .stage2_en   (stage2_en),
    .op_unsigned (op_unsigned),
    .rm_q        (rm_q),
    .int_q       (int_q),
    .i2f_result  (i2f_result),
    .i2f_nx      (i2f_nx)
  );

  fcvt_fp_to_int f2i_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .stage1_en   (stage1_en),
    .stage2_en   (stage2_en),
    .op_unsigned (op_unsigned),
    .rm_q        (rm_q),
    .fp_q        (fp_q),
    .f2i_result  (f2i_result),
    .f2i_nv      (f2i_nv),
    .f2i_nx      (f2i_nx)
  );

endmodule

`default_nettype wire

// File: verif/fcvt_clock_gen.sv
//--------------------------------------------------------------------------
// Testbench clock (20 ns period) and active-low reset for two cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fcvt_clock_gen (
  output logic clk,
  output logic reset_n
);

  localparam real HALF_PERIOD = 10.0;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Released on the second rising edge
  initial begin
    reset_n = 1'b0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/fcvt_unit_tb.sv
//--------------------------------------------------------------------------
// Conversion unit testbench: directed, special, handshake and random
// cases checked against an integer reference model
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fcvt_unit_tb import fcvt_pkg::*; ;

  // About 1000 conversions of 4 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 6000;

  logic     clk;
  logic     reset_n;
  logic     start;
  fcvt_op_t op;
  rm_t      rm;
  word_t    int_operand;
  fp32_t    fp_operand;
  logic     busy;
  logic     done;
  word_t    int_result;
  fp32_t    fp_result;
  logic     flag_nv;
  logic     flag_nx;

  int cyc = 0;
  int errors = 0;
  int checked = 0;

  // Expected results, one entry per accepted start
  word_t exp_res_q[$];
  logic  exp_nv_q[$];
  logic  exp_nx_q[$];
  logic  is_f2i_q[$];
  int    acc_q[$];

  word_t i2f_vals [11] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff,
                           32'h8000_0000, 32'h0100_0001, 32'h0100_0003, 32'h01ff_ffff,
                           32'h7fff_ffc0, 32'h1234_5678, 32'hfedc_ba98};
  fp32_t f2i_vals [16] = '{32'h3f00_0000, 32'hbf00_0000, 32'h3fc0_0000, 32'hbfc0_0000,
                           32'h4020_0000, 32'hc020_0000, 32'h4eff_ffff, 32'hcf00_0000,
                           32'h4f7f_ffff, 32'h3f40_0000, 32'h3e80_0000, 32'hc049_0fdb,
                           32'h3f7f_ffff, 32'h0000_0001, 32'h8000_0000, 32'h4b7f_ffff};
  // NaNs, infinities, huge exponents, negatives for the unsigned op
  fp32_t special_vals [10] = '{32'h7fc0_0000, 32'h7f80_0001, 32'hff80_0000, 32'h7f80_0000,
                               32'h5f00_0000, 32'hdf00_0000, 32'h4f80_0000, 32'hbf80_0000,
                               32'hcf00_0001, 32'hbe80_0000};

  fcvt_clock_gen clk_gen_i (
    .clk     (clk),
    .reset_n (reset_n)
  );

  fcvt_unit dut_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       (start),
    .op          (op),
    .rm          (rm),
    .int_operand (int_operand),
    .fp_operand  (fp_operand),
    .busy        (busy),
    .done        (done),
    .int_result  (int_result),
    .fp_result   (fp_result),
    .flag_nv     (flag_nv),
    .flag_nx     (flag_nx)
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  // Rounding from the discarded remainder compared against half an ulp
  function automatic logic rounds_away(input rm_t m, input logic neg, input logic odd,
                                       input logic above, input logic tie,
                                       input logic inexact);
    case (m)
      3'd0:    return above | (tie & odd);
      3'd2:    return neg & inexact;
      3'd3:    return ~neg & inexact;
      3'd4:    return above | tie;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void fcvt_model(input fcvt_op_t o, input rm_t m, input word_t iv,
                                     input fp32_t fv, output word_t res,
                                     output logic nv, output logic nx);
    logic            neg;
    logic            above;
    logic            tie;
    logic            inexact;
    longint unsigned mag;
    longint unsigned q;
    longint unsigned r;
    longint unsigned half;
    int              p;
    int              s;
    int              e;
    logic            out;
    word_t           sat_pos;
    word_t           sat_neg;
    nv      = 1'b0;
    above   = 1'b0;
    tie     = 1'b0;
    inexact = 1'b0;
    if (o[1]) begin
      // Integer to single
      neg = ~o[0] & iv[31];
      mag = neg ? (64'h1_0000_0000 - {32'd0, iv}) : {32'd0, iv};
      res = '0;
      if (mag != 0) begin
        p = 31;
        while (!mag[p]) p--;
        if (p <= 23) begin
          q = mag << (23 - p);
        end else begin
          s       = p - 23;
          q       = mag >> s;
          r       = mag & ((64'd1 << s) - 1);
          half    = 64'd1 << (s - 1);
          above   = r > half;
          tie     = r == half;
          inexact = r != 0;
        end
        e = FP_BIAS + p;
        q = q + rounds_away(m, neg, q[0], above, tie, inexact);
        // Mantissa overflow moves to the next binade
        if (q == (64'd1 << 24)) begin
          q = q >> 1;
          e = e + 1;
        end
        res = {neg, e[7:0], q[22:0]};
      end
      nx = inexact;
    end else begin
      // Single to integer
      neg     = fv[31];
      e       = int'(fv[30:23]);
      sat_pos = o[0] ? 32'hffff_ffff : 32'h7fff_ffff;
      sat_neg = o[0] ? 32'h0000_0000 : 32'h8000_0000;
      nx      = 1'b0;
      if (e == 255 && fv[22:0] != 0) begin
        res = sat_pos;
        nv  = 1'b1;
      end else if (e == 255 || e - FP_BIAS > 31) begin
        res = neg ? sat_neg : sat_pos;
        nv  = 1'b1;
      end else begin
        mag = (e != 0) ? ((64'd1 << 23) | fv[22:0]) : {41'd0, fv[22:0]};
        if (e == 0) e = 1;
        if (e >= 150) begin
          q = mag << (e - 150);
        end else if (150 - e > 24) begin
          // Below half of one, only inexactness survives
          q       = 0;
          inexact = mag != 0;
        end else begin
          s       = 150 - e;
          q       = mag >> s;
          r       = mag & ((64'd1 << s) - 1);
          half    = 64'd1 << (s - 1);
          above   = r > half;
          tie     = r == half;
          inexact = r != 0;
        end
        q = q + rounds_away(m, neg, q[0], above, tie, inexact);
        if (o[0]) out = neg ? (q != 0) : (q > 64'hffff_ffff);
        else out = neg ? (q > 64'h8000_0000) : (q > 64'h7fff_ffff);
        if (out) begin
          res = neg ? sat_neg : sat_pos;
          nv  = 1'b1;
        end else begin
          res = neg ? 32'(64'd0 - q) : 32'(q);
          nx  = inexact;
        end
      end
    end
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  task automatic issue(input fcvt_op_t o, input rm_t m, input word_t iv, input fp32_t fv);
    word_t r;
    logic  v;
    logic  x;
    while (busy) begin
      @(posedge clk);
      #2;
    end
    op          = o;
    rm          = m;
    int_operand = iv;
    fp_operand  = fv;
    start       = 1'b1;
    fcvt_model(o, m, iv, fv, r, v, x);
    @(posedge clk);
    #2;
    start = 1'b0;
    // Scramble inputs, the DUT works on its captured copy
    int_operand = $urandom;
    fp_operand  = $urandom;
    assert (busy) else begin
      errors++;
      $display("Start at %0t ns was not accepted while the unit was idle", $time);
    end
    exp_res_q.push_back(r);
    exp_nv_q.push_back(v);
    exp_nx_q.push_back(x);
    is_f2i_q.push_back(~o[1]);
    acc_q.push_back(cyc);
  endtask

  task automatic wait_idle();
    while (busy || done || exp_res_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Output that must read as zero
  task automatic expect_zero(input string name, input word_t act);
    assert (act == '0) else begin
      errors++;
      $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, 32'd0, act);
    end
  endtask

  // --------------------------------------------------------------------------
  // Compare process, samples the cycle in which done is high
  // --------------------------------------------------------------------------
  always @(posedge clk) begin : compare
    word_t act;
    word_t other;
    word_t exp_res;
    logic  exp_nv;
    logic  exp_nx;
    logic  is_f2i;
    string act_name;
    string other_name;
    int    acc;
    if (done) begin
      if (exp_res_q.size() == 0) begin
        errors++;
        $display("Done pulse at %0t ns with no conversion pending", $time);
      end else begin
        exp_res = exp_res_q.pop_front();
        exp_nv  = exp_nv_q.pop_front();
        exp_nx  = exp_nx_q.pop_front();
        acc     = acc_q.pop_front();
        is_f2i  = is_f2i_q.pop_front();
        if (is_f2i) begin
          act        = int_result;
          act_name   = "int_result";
          other      = fp_result;
          other_name = "fp_result";
        end else begin
          act        = fp_result;
          act_name   = "fp_result";
          other      = int_result;
          other_name = "int_result";
        end
        checked++;
        assert (cyc - acc == 3) else begin
          errors++;
          $display("Done came %0d cycles after acceptance at %0t ns", cyc - acc, $time);
        end
        assert (act == exp_res) else begin
          errors++;
          $display("[FAIL] %0t ns %s: expected %h, got %h", $time, act_name, exp_res, act);
        end
        // Result of the unused datapath is cleared
        expect_zero(other_name, other);
        assert (flag_nv == exp_nv) else begin
          errors++;
          $display("[FAIL] %0t ns flag_nv: expected %b, got %b", $time, exp_nv, flag_nv);
        end
        assert (flag_nx == exp_nx) else begin
          errors++;
          $display("[FAIL] %0t ns flag_nx: expected %b, got %b", $time, exp_nx, flag_nx);
        end
      end
    end
  end

  // Timeout
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d conversions pending", cyc,
               exp_res_q.size());
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    start       = 1'b0;
    op          = OP_W_S;
    rm          = RM_RNE;
    int_operand = '0;
    fp_operand  = '0;
    void'($urandom(32'h77e2_8176));
    wait (reset_n === 1'b1);
    @(posedge clk);
    #2;
    // Reset values
    expect_zero("busy", 32'(busy));
    expect_zero("done", 32'(done));
    expect_zero("int_result", int_result);
    expect_zero("fp_result", fp_result);
    expect_zero("flag_nv", 32'(flag_nv));
    expect_zero("flag_nx", 32'(flag_nx));

    // Directed integer to single, both signednesses, every mode
    foreach (i2f_vals[i])
      for (int m = 0; m < 5; m++) begin
        issue(OP_S_W, rm_t'(m), i2f_vals[i], '0);
        issue(OP_S_WU, rm_t'(m), i2f_vals[i], '0);
      end

    // Directed single to integer, then special inputs
    foreach (f2i_vals[i])
      for (int m = 0; m < 5; m++) begin
        issue(OP_W_S, rm_t'(m), '0, f2i_vals[i]);
        issue(OP_WU_S, rm_t'(m), '0, f2i_vals[i]);
      end
    foreach (special_vals[i])
      for (int m = 0; m < 5; m++) begin
        issue(OP_W_S, rm_t'(m), '0, special_vals[i]);
        issue(OP_WU_S, rm_t'(m), '0, special_vals[i]);
      end
    wait_idle();

    // Start held high while busy must be ignored
    issue(OP_S_W, RM_RNE, 32'h0000_0064, '0);
    start       = 1'b1;
    op          = OP_W_S;
    fp_operand  = 32'h4120_0000;
    repeat (2) @(posedge clk);
    #2;
    start = 1'b0;
    wait_idle();

    // Next start accepted in the done cycle
    issue(OP_S_WU, RM_RUP, 32'h0123_4567, '0);
    while (busy) begin
      @(posedge clk);
      #2;
    end
    assert (done) else begin
      errors++;
      $display("Unit went idle at %0t ns without a done pulse", $time);
    end
    issue(OP_W_S, RM_RDN, '0, 32'hc0a0_0000);
    wait_idle();

    // Random operations over all codes and bit patterns
    repeat (600) begin
      if ($urandom_range(0, 1))
        fp_operand = $urandom;
      else
        fp_operand = {1'($urandom), 8'($urandom_range(100, 160)), 23'($urandom)};
      issue(fcvt_op_t'($urandom_range(0, 3)), rm_t'($urandom_range(0, 7)), $urandom,
            fp_operand);
    end
    wait_idle();

    $display("Errors: %0d in %0d conversions checked", errors, checked);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fcvt_unit.f
source/fcvt_pkg.sv
source/fcvt_ctrl.sv
source/fcvt_int_to_fp.sv
source/fcvt_fp_to_int.sv
source/fcvt_unit.sv
verif/fcvt_clock_gen.sv
verif/fcvt_unit_tb.sv
